// ==== Makefile ====
# Verilator flow for the fetch predictor testbench
TOP := tb_fetch_predictor

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f verilog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// ==== design/fetch_pkg.sv ====
// Types shared by the fetch-side next-PC predictor
// Addresses are 40 bits, stack depth is a power of two
// Stage structs are packed so they can be registered as one word

package fetch_pkg;

    // Address space
    localparam int unsigned addr_w_c = 40;
    typedef logic [addr_w_c-1:0] addr_t;

    // Return address stack geometry
    localparam int unsigned ras_len_c     = 4;               // log2 of depth
    localparam int unsigned ras_entries_c = 2 ** ras_len_c;  // 16 entries

    // Input item, one fetched instruction
    typedef struct packed {
        addr_t             pc;
        riscv_pkg::instr_u instr;
    } fetch_req_t;

    // Stage 1 result, classification plus precomputed targets
    typedef struct packed {
        addr_t pc;
        addr_t link_addr;   // PC+4
        addr_t jal_target;  // PC + J immediate
        logic  is_call;     // Push link
        logic  is_ret;      // Pop for target
        logic  is_jal;
        logic  is_jalr;
    } predecode_t;

    // Output item
    typedef struct packed {
        addr_t pc;
        addr_t next_pc;
        logic  target_unknown;  // Indirect jump, PC+4 is a guess
    } predict_t;

endpackage

// ==== design/fetch_predictor_top.sv ====
// Return-address prediction path of the fetch unit
// Two-stage pipeline, 2 cycles latency, one item per cycle
// No redirect or mispredict recovery, stack is never repaired
// Valid/ready stream on both sides

module fetch_predictor_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  req_valid_i,
    input  fetch_pkg::fetch_req_t req_i,
    output logic                  req_ready_o,
    output logic                  pred_valid_o,
    output fetch_pkg::predict_t   pred_o,
    input  logic                  pred_ready_i
);

    import fetch_pkg::*;

    logic       s1_valid;
    predecode_t s1;
    logic       s1_ready;
    logic       push;
    logic       pop;
    addr_t      push_addr;
    addr_t      top_addr;

    // Stage 1
    rv_predecoder i_rv_predecoder (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .s1_valid_o  (s1_valid),
        .s1_o        (s1),
        .s1_ready_i  (s1_ready)
    );

    return_address_stack i_return_address_stack (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .push_i      (push),
        .pop_i       (pop),
        .push_addr_i (push_addr),
        .top_addr_o  (top_addr)
    );

    // Stage 2
    next_pc_selector i_next_pc_selector (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .s1_valid_i   (s1_valid),
        .s1_i         (s1),
        .s1_ready_o   (s1_ready),
        .top_addr_i   (top_addr),
        .push_o       (push),
        .pop_o        (pop),
        .push_addr_o  (push_addr),
        .pred_valid_o (pred_valid_o),
        .pred_o       (pred_o),
        .pred_ready_i (pred_ready_i)
    );

endmodule

// ==== design/next_pc_selector.sv ====
// Second predictor stage, one registered cycle
// Reads the stack top combinationally for returns
// Stack is updated on the same edge that loads the output
// Push/pop only fire on an accept, so stalls never repeat them

module next_pc_selector (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  s1_valid_i,
    input  fetch_pkg::predecode_t s1_i,
    output logic                  s1_ready_o,
    input  fetch_pkg::addr_t      top_addr_i,
    output logic                  push_o,
    output logic                  pop_o,
    output fetch_pkg::addr_t      push_addr_o,
    output logic                  pred_valid_o,
    output fetch_pkg::predict_t   pred_o,
    input  logic                  pred_ready_i
);

    import fetch_pkg::*;

    predict_t pred_d;
    predict_t pred_q;
    logic     pred_valid_q;
    logic     accept;

    assign s1_ready_o = !pred_valid_q || pred_ready_i;
    assign accept     = s1_valid_i && s1_ready_o;

    // Stack control
    assign push_o      = accept && s1_i.is_call;
    assign pop_o       = accept && s1_i.is_ret;
    assign push_addr_o = s1_i.link_addr;

    // Next PC select, return has priority
    always_comb begin
        pred_d.pc             = s1_i.pc;
        pred_d.next_pc        = s1_i.link_addr;  // Default fall-through
        pred_d.target_unknown = 1'b0;
        if (s1_i.is_ret) begin
            pred_d.next_pc = top_addr_i;
        end else if (s1_i.is_jal) begin
            pred_d.next_pc = s1_i.jal_target;
        end else if (s1_i.is_jalr) begin
            pred_d.target_unknown = 1'b1;  // No BTB to ask
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pred_valid_q <= 1'b0;
        end else if (s1_ready_o) begin
            pred_valid_q <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            pred_q <= pred_d;
        end
    end

    assign pred_valid_o = pred_valid_q;
    assign pred_o       = pred_q;

    // Stage 1 keeps its item steady through a stall
    a_s1_stable : assert property (@(posedge clk_i) disable iff (!rstn_i)
        s1_valid_i && !s1_ready_o |=> s1_valid_i && $stable(s1_i));

endmodule

// ==== design/return_address_stack.sv ====
// Circular return address stack, ras_entries_c deep
// Overflow wraps and overwrites the oldest entry
// Underflow wraps too and returns stale data
// top_addr_o is combinational from the head pointer
// Push and pop together replace the top entry in place

module return_address_stack (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            push_i,
    input  logic            pop_i,
    input  fetch_pkg::addr_t push_addr_i,
    output fetch_pkg::addr_t top_addr_o
);

    import fetch_pkg::*;

    addr_t                stack_q [ras_entries_c];  // Link address storage
    logic [ras_len_c-1:0] head_q;                   // Next free slot
    logic [ras_len_c-1:0] head_below;               // Current top

    assign head_below = head_q - 1'b1;  // Wraps at zero

    // Head pointer moves only on a lone push or pop
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            head_q <= '0;
        end else if (push_i && !pop_i) begin
            head_q <= head_q + 1'b1;
        end else if (pop_i && !push_i) begin
            head_q <= head_q - 1'b1;
        end
    end

    // Entry writes
    always_ff @(posedge clk_i) begin
        if (push_i && pop_i) begin
            stack_q[head_below] <= push_addr_i;  // Replace top
        end else if (push_i) begin
            stack_q[head_q] <= push_addr_i;      // New top
        end
    end

    assign top_addr_o = stack_q[head_below];

    // Stack control must come from a settled selector
    a_ctrl_known : assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown({push_i, pop_i}));

endmodule

// ==== design/riscv_pkg.sv ====
// RV32/RV64 base encodings needed by the return-address predictor
// Only JAL and JALR are decoded, compressed forms are not handled
// Link registers follow the standard calling convention hint (x1, x5)

package riscv_pkg;

    // Major opcodes
    localparam logic [6:0] opcode_jal_c  = 7'b1101111;
    localparam logic [6:0] opcode_jalr_c = 7'b1100111;

    // Link registers used for call/return hints
    localparam logic [4:0] reg_ra_c = 5'd1;  // x1, return address
    localparam logic [4:0] reg_t0_c = 5'd5;  // x5, alternate link

    // J format, immediate bits are scrambled in the word
    typedef struct packed {
        logic       imm20;     // Sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_j_t;

    // I format, used for JALR
    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // One instruction word, two views
    // rd and opcode sit at the same bits in both
    typedef union packed {
        instr_j_t j;  // JAL
        instr_i_t i;  // JALR
    } instr_u;

endpackage

// ==== design/rv_predecoder.sv ====
// First stage of the predictor, one registered cycle
// Classifies JAL/JALR as call, return or plain jump
// Assumes uncompressed 32-bit instructions only
// Holds its output while the next stage stalls

module rv_predecoder (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  req_valid_i,
    input  fetch_pkg::fetch_req_t req_i,
    output logic                  req_ready_o,
    output logic                  s1_valid_o,
    output fetch_pkg::predecode_t s1_o,
    input  logic                  s1_ready_i
);

    import riscv_pkg::*;
    import fetch_pkg::*;

    instr_u     instr;
    logic       is_jal;
    logic       is_jalr;
    logic       rd_link;
    logic       rs1_link;
    addr_t      jal_imm;
    predecode_t s1_d;
    predecode_t s1_q;
    logic       s1_valid_q;
    logic       accept;

    assign instr = req_i.instr;

    // Opcode and rd are common to both views
    assign is_jal  = (instr.i.opcode == opcode_jal_c);
    assign is_jalr = (instr.i.opcode == opcode_jalr_c) && (instr.i.funct3 == 3'b000);

    assign rd_link  = (instr.i.rd == reg_ra_c) || (instr.i.rd == reg_t0_c);
    assign rs1_link = (instr.i.rs1 == reg_ra_c) || (instr.i.rs1 == reg_t0_c);

    // J immediate, sign extended to address width
    assign jal_imm = {{(addr_w_c-20){instr.j.imm20}}, instr.j.imm19_12,
                      instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        s1_d.pc         = req_i.pc;
        s1_d.link_addr  = req_i.pc + addr_t'(4);
        s1_d.jal_target = req_i.pc + jal_imm;
        s1_d.is_jal     = is_jal;
        s1_d.is_jalr    = is_jalr;
        s1_d.is_call    = (is_jal || is_jalr) && rd_link;
        // rd == rs1 means a plain call, not a coroutine swap
        s1_d.is_ret     = is_jalr && rs1_link && (instr.i.rd != instr.i.rs1);
    end

    // Ready when empty or draining this cycle
    assign req_ready_o = !s1_valid_q || s1_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            s1_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            s1_q <= s1_d;  // Payload, no reset
        end
    end

    assign s1_valid_o = s1_valid_q;
    assign s1_o       = s1_q;

    // Upstream keeps the request steady until taken
    a_req_stable : assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i));

endmodule

// ==== testbench/ras_stim.txt ====
# pc(hex, 40 bit)  instr(hex)  expected_next_pc(hex)  expected_target_unknown
# One instruction per line, sent in order; outputs must match in the same order
0000001000 00000013 0000001004 0
0000001004 00000463 0000001008 0
0000001008 0100006F 0000001018 0
0000001018 FF9FF06F 0000001010 0
0000001010 100000EF 0000001110 0
0000001110 200000EF 0000001310 0
0000001310 040002EF 0000001350 0
0000001350 00028067 0000001314 0
0000001314 00008067 0000001114 0
0000001114 00008067 0000001014 0
0000001014 080000EF 0000001094 0
0000001094 020000EF 00000010B4 0
00000010B4 000082E7 0000001098 0
0000001098 00028067 00000010B8 0
00000010B8 00008067 0000001018 0
0000001018 00030067 000000101C 1
000000101C 000300E7 0000001020 1
0000002000 00008067 0000001020 0
0000001020 000080E7 0000001024 1
0000003000 00008067 0000001024 0
0000001024 000012B7 0000001028 0
1234566FFC 100000EF 12345670FC 0
12345670FC 00008067 1234567000 0
1234567000 00000013 1234567004 0
1234567004 FF9FF06F 1234566FFC 0
FFFFFFFFFC 00000013 0000000000 0

// ==== testbench/tb_fetch_predictor.sv ====
// Testbench for the fetch-side return address predictor
// Stimulus and expected next PCs come from testbench/ras_stim.txt
// Run from the project root so the relative stimulus path resolves
// Random output back-pressure and input gaps, fixed seed
// Stops at the first mismatch

module tb_fetch_predictor;

    import fetch_pkg::*;

    logic       clk_i;
    logic       rstn_i;
    logic       req_valid_i;
    fetch_req_t req_i;
    logic       req_ready_o;
    logic       pred_valid_o;
    predict_t   pred_o;
    logic       pred_ready_i;

    // Stimulus table, one entry per instruction
    addr_t       pc_q[$];
    logic [31:0] instr_q[$];
    addr_t       next_q[$];
    logic        unk_q[$];

    int n_items;
    int in_idx;     // Next item to send
    int out_idx;    // Next item expected out

    fetch_predictor_top i_fetch_predictor_top (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .pred_valid_o (pred_valid_o),
        .pred_o       (pred_o),
        .pred_ready_i (pred_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;  // Period 20
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h (item %0d)",
                     name, actual, expected, out_idx);
            abort_run("stopping at first mismatch");
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [39:0] pc;
        logic [39:0] nxt;
        logic [31:0] instr;
        logic [3:0]  unk;
        fd = $fopen("testbench/ras_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open stimulus file testbench/ras_stim.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;  // Blank or comment
            end
            n = $sscanf(line, "%h %h %h %h", pc, instr, nxt, unk);
            if (n != 4) begin
                abort_run({"malformed stimulus line: ", line});
            end
            pc_q.push_back(pc);
            instr_q.push_back(instr);
            next_q.push_back(nxt);
            unk_q.push_back(unk[0]);
        end
        $fclose(fd);
        n_items = pc_q.size();
        if (n_items == 0) begin
            abort_run("stimulus file holds no instructions");
        end
    endtask

    initial begin
        logic in_fire;
        logic out_fire;
        int   idle;
        void'($urandom(18119));
        rstn_i       = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        pred_ready_i = 1'b0;
        in_idx       = 0;
        out_idx      = 0;
        in_fire      = 1'b0;
        idle         = 0;
        load_stimulus();

        repeat (8) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;
        check_value("req_ready_o", 64'(req_ready_o), 64'd1);   // Empty after reset
        check_value("pred_valid_o", 64'(pred_valid_o), 64'd0);

        while (out_idx < n_items) begin
            // New item only once the previous one was taken
            if (in_fire || !req_valid_i) begin
                if (in_idx < n_items && ($urandom % 5) != 0) begin
                    req_valid_i = 1'b1;
                    req_i.pc    = pc_q[in_idx];
                    req_i.instr = instr_q[in_idx];
                end else begin
                    req_valid_i = 1'b0;
                end
            end
            pred_ready_i = ($urandom % 10) >= 3;  // ~30% stall

            @(negedge clk_i);  // Mid-cycle, everything settled
            in_fire  = req_valid_i && req_ready_o;
            out_fire = pred_valid_o && pred_ready_i;
            if (out_fire) begin
                check_value("pred_o.pc", 64'(pred_o.pc), 64'(pc_q[out_idx]));
                check_value("pred_o.next_pc", 64'(pred_o.next_pc), 64'(next_q[out_idx]));
                check_value("pred_o.target_unknown", 64'(pred_o.target_unknown),
                            64'(unk_q[out_idx]));
                out_idx++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > 100) begin
                abort_run("no prediction came out for 100 cycles, pipeline is stuck");
            end

            @(posedge clk_i);
            #2;
            if (in_fire) begin
                in_idx++;
            end
        end

        // Drain, nothing extra may come out
        req_valid_i  = 1'b0;
        pred_ready_i = 1'b1;
        check_value("items sent", 64'(in_idx), 64'(n_items));
        repeat (4) begin
            @(negedge clk_i);
            check_value("pred_valid_o", 64'(pred_valid_o), 64'd0);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/riscv_pkg.sv
design/fetch_pkg.sv
design/rv_predecoder.sv
design/return_address_stack.sv
design/next_pc_selector.sv
design/fetch_predictor_top.sv
testbench/tb_fetch_predictor.sv
